//--- apb_master.sv
`timescale 1ns/1ps

module apb_master (
  input  logic                                cpu_clk,
  input  logic                                cpu_resetn,
  input  cpu_ctrl_pkg::cu_ctrl_t              ctrl,
  input  logic [cpu_isa_pkg::OPERAND_W-1:0]   addr,
  input  logic                                cr_bit,
  input  logic                                pready,
  output cpu_ctrl_pkg::apb_req_t              apb,
  output logic                                apb_done
);

  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;

  apb_state_e           apb_state;
  logic                 apb_start;
  logic [OPERAND_W-1:0] paddr_q;
  logic                 pwrite_q;
  logic                 pwdata_q;

  assign apb_start = (apb_state == APB_IDLE) && ctrl.apb_en;
  assign apb_done  = (apb_state == APB_ACCESS) && pready;

  // ----------------------------------------
  // Transfer phases
  // ----------------------------------------
  always_ff @(posedge cpu_clk or negedge cpu_resetn)
  begin
    if (!cpu_resetn)
      apb_state <= APB_IDLE;
    else
    begin
      case (apb_state)
        APB_IDLE:
          if (ctrl.apb_en)
            apb_state <= APB_SETUP;
        APB_SETUP:
          apb_state <= APB_ACCESS;               // Always a single setup cycle
        APB_ACCESS:
          if (pready)
            apb_state <= APB_IDLE;
        default:
          apb_state <= APB_IDLE;
      endcase
    end
  end

  // Address, direction and data fixed for the whole transfer
  always_ff @(posedge cpu_clk)
  begin
    if (apb_start)
    begin
      paddr_q  <= addr;
      pwrite_q <= ctrl.apb_wr;
      pwdata_q <= cr_bit;
    end
  end

  assign apb = '{psel:    (apb_state != APB_IDLE),
                 penable: (apb_state == APB_ACCESS),
                 pwrite:  pwrite_q,
                 paddr:   paddr_q,
                 pwdata:  pwdata_q};

endmodule

//--- bit_cpu_checker.sv
`timescale 1ns/1ps

module bit_cpu_checker (
  input logic                      cpu_clk,
  input logic                      cpu_resetn,
  input cpu_ctrl_pkg::apb_req_t    apb,
  input logic                      pready
);

  int assert_errors = 0;                         // Failed assertions so far

  // ----------------------------------------
  // APB protocol rules
  // ----------------------------------------
  penable_needs_psel: assert property (
    @(posedge cpu_clk) disable iff (!cpu_resetn)
    apb.penable |-> apb.psel)
  else
  begin
    $error("penable high while psel is low");
    assert_errors++;
  end

  // Setup leads into access, a wait state keeps the access phase
  setup_then_access: assert property (
    @(posedge cpu_clk) disable iff (!cpu_resetn)
    (apb.psel && !(apb.penable && pready)) |=> (apb.psel && apb.penable))
  else
  begin
    $error("APB setup or wait state not followed by the access phase");
    assert_errors++;
  end

  // Wait states must not disturb the request
  stable_in_transfer: assert property (
    @(posedge cpu_clk) disable iff (!cpu_resetn)
    (apb.psel && $past(apb.psel)) |-> ($stable(apb.paddr) && $stable(apb.pwrite)))
  else
  begin
    $error("paddr or pwrite changed while psel was high");
    assert_errors++;
  end

endmodule

bind apb_master bit_cpu_checker chk0 (
  .cpu_clk    (cpu_clk),
  .cpu_resetn (cpu_resetn),
  .apb        (apb),
  .pready     (pready)
);

//--- bit_cpu_monitor.sv
`timescale 1ns/1ps

module bit_cpu_monitor #(
  parameter int PM_ADDR_W = 8
) (
  input  logic                     cpu_clk,
  input  logic                     cpu_resetn,
  input  logic                     cpu_run,
  input  logic [PM_ADDR_W-1:0]     pm_addr,
  input  cpu_ctrl_pkg::apb_req_t   apb,
  input  logic                     pready,
  output int                       seen_count,
  output int                       mismatch_count,
  output int                       other_count
);

  import cpu_isa_pkg::*;

  typedef struct packed {
    logic [OPERAND_W-1:0] paddr;
    logic                 pwrite;
    logic                 pwdata;                // Only meaningful for writes
  } xfer_t;

  xfer_t exp_q [$];                              // Filled by the reference model
  xfer_t exp_x;

  initial
  begin
    seen_count     = 0;
    mismatch_count = 0;
    other_count    = 0;
  end

  task automatic expect_transfer(input logic [OPERAND_W-1:0] paddr, input logic pwrite,
                                 input logic pwdata);
    xfer_t x;
    x.paddr  = paddr;
    x.pwrite = pwrite;
    x.pwdata = pwdata;
    exp_q.push_back(x);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] got_val);
    $display("MISMATCH %s expected 0x%h got 0x%h at %0t", name, exp_val, got_val, $time);
    mismatch_count++;
  endtask

  // ----------------------------------------
  // Sampled mid-cycle, all inputs settled
  // ----------------------------------------
  always @(negedge cpu_clk)
  begin
    if (!cpu_run)
    begin
      if (apb.psel !== 1'b0)
        report_mismatch("psel", 0, apb.psel);
      if (apb.penable !== 1'b0)
        report_mismatch("penable", 0, apb.penable);
      if (pm_addr !== '0)
        report_mismatch("pm_addr", 0, pm_addr);
    end
    if (cpu_resetn && apb.psel && apb.penable && pready) // Transfer ends at next edge
    begin
      if (seen_count >= exp_q.size())
      begin
        $display("Unexpected APB transfer to address 0x%h after all %0d expected ones",
                 apb.paddr, exp_q.size());
        other_count++;
      end
      else
      begin
        exp_x = exp_q[seen_count];
        if (apb.paddr !== exp_x.paddr)
          report_mismatch($sformatf("paddr (transfer %0d)", seen_count), exp_x.paddr, apb.paddr);
        if (apb.pwrite !== exp_x.pwrite)
          report_mismatch($sformatf("pwrite (transfer %0d)", seen_count), exp_x.pwrite,
                          apb.pwrite);
        else if (exp_x.pwrite && apb.pwdata !== exp_x.pwdata)
          report_mismatch($sformatf("pwdata (transfer %0d)", seen_count), exp_x.pwdata,
                          apb.pwdata);
      end
      seen_count++;
    end
  end

endmodule

//--- bit_cpu_top.sv
`timescale 1ns/1ps

module bit_cpu_top #(
  parameter int DM_ADDR_W = 8,                   // Data memory address bits
  parameter int PM_ADDR_W = 8                    // Program memory address bits
) (
  input  logic                     cpu_clk,
  input  logic                     cpu_resetn,
  input  logic                     cpu_run,
  input  cpu_isa_pkg::instr_t      pm_data,      // Combinational ROM data
  output logic [PM_ADDR_W-1:0]     pm_addr,
  input  logic                     pready,
  input  logic                     prdata,
  output cpu_ctrl_pkg::apb_req_t   apb
);

  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;

  instr_t   ir;                                  // Instruction register
  cu_ctrl_t ctrl;
  logic     cr_bit;
  logic     store_bit;
  logic     dm_bit;
  logic     apb_done;

  always_ff @(posedge cpu_clk)
  begin
    if (ctrl.pm_en)
      ir <= pm_data;
  end

  // ----------------------------------------
  // Core blocks
  // ----------------------------------------
  cpu_sequencer u_sequencer (
    .cpu_clk    (cpu_clk),
    .cpu_resetn (cpu_resetn),
    .cpu_run    (cpu_run),
    .opcode     (ir.opcode),
    .cr_bit     (cr_bit),
    .apb_done   (apb_done),
    .ctrl       (ctrl)
  );

  program_counter #(.PM_ADDR_W(PM_ADDR_W)) u_program_counter (
    .cpu_clk    (cpu_clk),
    .cpu_resetn (cpu_resetn),
    .ctrl       (ctrl),
    .target     (ir.operand),
    .pm_addr    (pm_addr)
  );

  bit_logic_unit u_bit_logic_unit (
    .cpu_clk    (cpu_clk),
    .cpu_resetn (cpu_resetn),
    .ctrl       (ctrl),
    .opcode     (ir.opcode),
    .dm_bit     (dm_bit),
    .prdata     (prdata),
    .apb_done   (apb_done),
    .cr_bit     (cr_bit),
    .store_bit  (store_bit)
  );

  bit_data_memory #(.DM_ADDR_W(DM_ADDR_W)) u_bit_data_memory (
    .cpu_clk    (cpu_clk),
    .ctrl       (ctrl),
    .addr       (ir.operand),
    .store_bit  (store_bit),
    .dm_bit     (dm_bit)
  );

  apb_master u_apb_master (
    .cpu_clk    (cpu_clk),
    .cpu_resetn (cpu_resetn),
    .ctrl       (ctrl),
    .addr       (ir.operand),                    // Full operand is the APB address
    .cr_bit     (cr_bit),
    .pready     (pready),
    .apb        (apb),
    .apb_done   (apb_done)
  );

endmodule

//--- bit_data_memory.sv
`timescale 1ns/1ps

module bit_data_memory #(
  parameter int DM_ADDR_W = 8                    // At most OPERAND_W
) (
  input  logic                                cpu_clk,
  input  cpu_ctrl_pkg::cu_ctrl_t              ctrl,
  input  logic [cpu_isa_pkg::OPERAND_W-1:0]   addr,
  input  logic                                store_bit,
  output logic                                dm_bit
);

  localparam int DM_DEPTH = 2**DM_ADDR_W;

  logic                 mem [0:DM_DEPTH-1];      // One bit per address
  logic [DM_ADDR_W-1:0] dm_addr;

  assign dm_addr = addr[DM_ADDR_W-1:0];          // Upper operand bits ignored

  // ----------------------------------------
  // Single port, read registered
  // ----------------------------------------
  always_ff @(posedge cpu_clk)
  begin
    if (ctrl.dm_en)
    begin
      if (ctrl.dm_wr)
        mem[dm_addr] <= store_bit;
      else
        dm_bit <= mem[dm_addr];                  // Used by CR in next phase
    end
  end

endmodule

//--- bit_logic_unit.sv
`timescale 1ns/1ps

module bit_logic_unit (
  input  logic                     cpu_clk,
  input  logic                     cpu_resetn,
  input  cpu_ctrl_pkg::cu_ctrl_t   ctrl,
  input  cpu_isa_pkg::opcode_e     opcode,
  input  logic                     dm_bit,
  input  logic                     prdata,
  input  logic                     apb_done,
  output logic                     cr_bit,
  output logic                     store_bit
);

  import cpu_isa_pkg::*;

  logic cr_next;

  // ----------------------------------------
  // Result of the current instruction
  // ----------------------------------------
  always_comb
  begin
    cr_next = cr_bit;
    case (opcode)
      OP_LD:     cr_next = dm_bit;
      OP_LDN:    cr_next = ~dm_bit;
      OP_AND:    cr_next = cr_bit & dm_bit;
      OP_ANDN:   cr_next = cr_bit & ~dm_bit;
      OP_OR:     cr_next = cr_bit | dm_bit;
      OP_ORN:    cr_next = cr_bit | ~dm_bit;
      OP_XOR:    cr_next = cr_bit ^ dm_bit;
      OP_XORN:   cr_next = cr_bit ^ ~dm_bit;
      OP_EQU:    cr_next = (cr_bit == dm_bit);
      OP_APB_RD: cr_next = apb_done ? prdata : cr_bit;  // Valid only at end of access
      default:   cr_next = cr_bit;
    endcase
  end

  always_ff @(posedge cpu_clk or negedge cpu_resetn)
  begin
    if (!cpu_resetn)
      cr_bit <= 1'b0;
    else if (ctrl.cr_en)
      cr_bit <= cr_next;
  end

  // ----------------------------------------
  // Data written back to memory
  // ----------------------------------------
  always_comb
  begin
    case (opcode)
      OP_STN:  store_bit = ~cr_bit;
      OP_S:    store_bit = 1'b1;
      OP_R:    store_bit = 1'b0;
      default: store_bit = cr_bit;             // ST
    endcase
  end

endmodule

//--- cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

  // ----------------------------------------
  // Sequencer and bus states
  // ----------------------------------------
  typedef enum logic [1:0] {
    CU_IDLE     = 2'b00,                         // Waiting for cpu_run
    CU_EXEC     = 2'b01,                         // First phase of an instruction
    CU_COMPLETE = 2'b10                          // Second phase, next fetch
  } cu_state_e;

  typedef enum logic [1:0] {
    APB_IDLE   = 2'b00,
    APB_SETUP  = 2'b01,                          // psel high, penable low
    APB_ACCESS = 2'b10                           // penable high until pready
  } apb_state_e;

  // ----------------------------------------
  // Control word from the sequencer
  // ----------------------------------------
  typedef struct packed {
    logic pc_en;                                 // Increment program counter
    logic pc_ld;                                 // Load jump target
    logic pm_en;                                 // Capture instruction word
    logic cr_en;                                 // Update current result
    logic dm_en;                                 // Data memory access
    logic dm_wr;                                 // Data memory write
    logic apb_en;                                // Start an APB transfer
    logic apb_wr;                                // Transfer direction
  } cu_ctrl_t;

  // ----------------------------------------
  // APB master request
  // ----------------------------------------
  typedef struct packed {
    logic                                psel;
    logic                                penable;
    logic                                pwrite;
    logic [cpu_isa_pkg::OPERAND_W-1:0]   paddr;
    logic                                pwdata;  // Single bit peripherals
  } apb_req_t;

endpackage

//--- cpu_isa_pkg.sv
package cpu_isa_pkg;

  // ----------------------------------------
  // Instruction field widths
  // ----------------------------------------
  localparam int OPCODE_W  = 5;                  // Opcode field
  localparam int OPERAND_W = 8;                  // Data, jump or APB address
  localparam int INSTR_W   = OPCODE_W + OPERAND_W;

  // ----------------------------------------
  // Opcodes
  // ----------------------------------------
  typedef enum logic [OPCODE_W-1:0] {
    OP_NOP    = 5'h00,                           // No operation
    OP_LD     = 5'h01,                           // CR = M
    OP_LDN    = 5'h02,                           // CR = !M
    OP_AND    = 5'h03,                           // CR = CR & M
    OP_ANDN   = 5'h04,                           // CR = CR & !M
    OP_OR     = 5'h05,                           // CR = CR | M
    OP_ORN    = 5'h06,                           // CR = CR | !M
    OP_XOR    = 5'h07,                           // CR = CR ^ M
    OP_XORN   = 5'h08,                           // CR = CR ^ !M
    OP_EQU    = 5'h09,                           // CR = (CR == M)
    OP_ST     = 5'h0A,                           // M = CR
    OP_STN    = 5'h0B,                           // M = !CR
    OP_S      = 5'h0C,                           // Set M when CR is 1
    OP_R      = 5'h0D,                           // Reset M when CR is 1
    OP_JMP    = 5'h0E,                           // Unconditional jump
    OP_JMPC   = 5'h0F,                           // Jump when CR is 1
    OP_JMPCN  = 5'h10,                           // Jump when CR is 0
    OP_APB_RD = 5'h11,                           // CR = peripheral bit
    OP_APB_WR = 5'h12                            // Peripheral bit = CR
  } opcode_e;

  // ----------------------------------------
  // Instruction word
  // ----------------------------------------
  typedef struct packed {
    opcode_e                opcode;              // Upper 5 bits
    logic [OPERAND_W-1:0]   operand;             // Lower 8 bits
  } instr_t;

endpackage

//--- cpu_sequencer.sv
`timescale 1ns/1ps

module cpu_sequencer (
  input  logic                     cpu_clk,
  input  logic                     cpu_resetn,
  input  logic                     cpu_run,
  input  cpu_isa_pkg::opcode_e     opcode,
  input  logic                     cr_bit,
  input  logic                     apb_done,
  output cpu_ctrl_pkg::cu_ctrl_t   ctrl
);

  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;

  cu_state_e cu_state;
  cu_state_e cu_nstate;

  // ----------------------------------------
  // Decode and next state
  // ----------------------------------------
  always_comb
  begin
    ctrl      = '0;
    cu_nstate = cu_state;
    case (cu_state)
      CU_IDLE:
      begin
        ctrl.pm_en = 1'b1;                       // Keep word at address 0 loaded
        if (cpu_run)
          cu_nstate = CU_EXEC;
      end
      CU_EXEC:
      begin
        cu_nstate  = CU_COMPLETE;
        ctrl.pc_en = 1'b1;                       // pc+1 unless a jump loads
        case (opcode)
          OP_LD, OP_LDN, OP_AND, OP_ANDN, OP_OR,
          OP_ORN, OP_XOR, OP_XORN, OP_EQU:
            ctrl.dm_en = 1'b1;                   // Fetch operand bit
          OP_ST, OP_STN:
          begin
            ctrl.dm_en = 1'b1;
            ctrl.dm_wr = 1'b1;
          end
          OP_S, OP_R:
          begin
            ctrl.dm_en = 1'b1;
            ctrl.dm_wr = cr_bit;                 // Only acts when CR is set
          end
          OP_JMP:
            ctrl.pc_ld = 1'b1;
          OP_JMPC:
            ctrl.pc_ld = cr_bit;
          OP_JMPCN:
            ctrl.pc_ld = ~cr_bit;
          OP_APB_RD:
            ctrl.apb_en = 1'b1;
          OP_APB_WR:
          begin
            ctrl.apb_en = 1'b1;
            ctrl.apb_wr = 1'b1;
          end
          default:
          begin
            ctrl.pc_ld = 1'b0;                   // NOP and unknown codes
          end
        endcase
      end
      CU_COMPLETE:
      begin
        cu_nstate  = CU_EXEC;
        ctrl.pm_en = 1'b1;                       // Fetch from updated pc
        case (opcode)
          OP_LD, OP_LDN, OP_AND, OP_ANDN, OP_OR,
          OP_ORN, OP_XOR, OP_XORN, OP_EQU:
            ctrl.cr_en = 1'b1;                   // Operand bit now registered
          OP_APB_RD, OP_APB_WR:
          begin
            // Hold the instruction until the slave ends the access phase
            ctrl.pm_en = apb_done;
            ctrl.cr_en = (opcode == OP_APB_RD);
            if (!apb_done)
              cu_nstate = CU_COMPLETE;
          end
          default:
          begin
            ctrl.cr_en = 1'b0;
          end
        endcase
      end
      default:
        cu_nstate = CU_IDLE;
    endcase
  end

  // ----------------------------------------
  // State register
  // ----------------------------------------
  always_ff @(posedge cpu_clk or negedge cpu_resetn)
  begin
    if (!cpu_resetn)
      cu_state <= CU_IDLE;
    else
      cu_state <= cu_nstate;
  end

endmodule

//--- list.f
cpu_isa_pkg.sv
cpu_ctrl_pkg.sv
cpu_sequencer.sv
program_counter.sv
bit_logic_unit.sv
bit_data_memory.sv
apb_master.sv
bit_cpu_top.sv
bit_cpu_checker.sv
bit_cpu_monitor.sv
tb_bit_cpu.sv

//--- program_counter.sv
`timescale 1ns/1ps

module program_counter #(
  parameter int PM_ADDR_W = 8                    // At most OPERAND_W
) (
  input  logic                                cpu_clk,
  input  logic                                cpu_resetn,
  input  cpu_ctrl_pkg::cu_ctrl_t              ctrl,
  input  logic [cpu_isa_pkg::OPERAND_W-1:0]   target,
  output logic [PM_ADDR_W-1:0]                pm_addr
);

  logic [PM_ADDR_W-1:0] pc_next;

  // Jump load wins over increment
  always_comb
  begin
    if (ctrl.pc_ld)
      pc_next = target[PM_ADDR_W-1:0];
    else
      pc_next = pm_addr + 1'b1;
  end

  always_ff @(posedge cpu_clk or negedge cpu_resetn)
  begin
    if (!cpu_resetn)
      pm_addr <= '0;
    else if (ctrl.pc_ld || ctrl.pc_en)
      pm_addr <= pc_next;
  end

endmodule

//--- tb_bit_cpu.sv
`timescale 1ns/1ps

module tb_bit_cpu;

  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;

  localparam int DM_ADDR_W       = 4;
  localparam int PM_ADDR_W       = 6;
  localparam int PM_DEPTH        = 2**PM_ADDR_W;
  localparam int DM_DEPTH        = 2**DM_ADDR_W;
  localparam int CLK_PERIOD      = 100;
  localparam int WATCHDOG_CYCLES = PM_DEPTH * (2 + 3 + 2) + 50;

  logic                 cpu_clk;
  logic                 cpu_resetn;
  logic                 cpu_run;
  instr_t               pm_data;
  logic [PM_ADDR_W-1:0] pm_addr;
  logic                 pready;
  logic                 prdata;
  apb_req_t             apb;

  instr_t rom         [0:PM_DEPTH-1];
  logic   rd_bits     [0:PM_DEPTH-1];            // prdata of each read, in order
  int     wait_cycles [0:PM_DEPTH-1];            // pready delay of each transfer
  int     exp_total;
  int     xfer_idx;
  int     rd_idx;
  int     wait_left;
  int     seed;
  int     seen_count;
  int     mismatch_count;
  int     other_count;
  int     assert_errors;

  always #(CLK_PERIOD / 2) cpu_clk = ~cpu_clk;

  assign pm_data = rom[pm_addr];                 // Combinational program ROM

  assign assert_errors = dut0.u_apb_master.chk0.assert_errors;

  bit_cpu_top #(.DM_ADDR_W(DM_ADDR_W), .PM_ADDR_W(PM_ADDR_W)) dut0 (
    .cpu_clk    (cpu_clk),
    .cpu_resetn (cpu_resetn),
    .cpu_run    (cpu_run),
    .pm_data    (pm_data),
    .pm_addr    (pm_addr),
    .pready     (pready),
    .prdata     (prdata),
    .apb        (apb)
  );

  bit_cpu_monitor #(.PM_ADDR_W(PM_ADDR_W)) mon0 (
    .cpu_clk        (cpu_clk),
    .cpu_resetn     (cpu_resetn),
    .cpu_run        (cpu_run),
    .pm_addr        (pm_addr),
    .apb            (apb),
    .pready         (pready),
    .seen_count     (seen_count),
    .mismatch_count (mismatch_count),
    .other_count    (other_count)
  );

  // ----------------------------------------
  // Random program, forward jumps only
  // ----------------------------------------
  task automatic build_program();
    int                   i;
    int                   r;
    int                   tgt;
    int                   max_tgt;
    int                   n_written;
    logic [DM_ADDR_W-1:0] a;
    logic [OPERAND_W-1:0] arg;
    logic                 written [0:DM_DEPTH-1];
    opcode_e              op;
    max_tgt   = 0;
    n_written = 0;
    for (i = 0; i < DM_DEPTH; i++)
      written[i] = 1'b0;
    for (i = 0; i < PM_DEPTH; i++)
    begin
      rd_bits[i]     = 1'($urandom);
      wait_cycles[i] = int'($urandom % 4);
    end
    for (i = 0; i < PM_DEPTH - 1; i++)
    begin
      r = int'($urandom % 16);
      if (r >= 4 && r < 8 && n_written == 0)
        r = 0;                                   // Nothing safe to load yet
      if (r < 4)
      begin
        op  = opcode_e'(OP_ST + $urandom % 4);
        a   = DM_ADDR_W'($urandom);
        arg = OPERAND_W'(a);
        // Counts only when no earlier jump can skip it
        if ((op == OP_ST || op == OP_STN) && i >= max_tgt && !written[a])
        begin
          written[a] = 1'b1;
          n_written++;
        end
      end
      else if (r < 8)
      begin
        op = opcode_e'(OP_LD + $urandom % 9);
        a  = DM_ADDR_W'($urandom);
        while (!written[a])
          a = a + 1'b1;
        arg = OPERAND_W'(a);
      end
      else if (r < 10)
      begin
        op  = opcode_e'(OP_JMP + $urandom % 3);
        tgt = i + 1 + int'($urandom % 4);
        if (tgt > PM_DEPTH - 1)
          tgt = PM_DEPTH - 1;
        if (tgt > max_tgt)
          max_tgt = tgt;
        arg = OPERAND_W'(tgt);
      end
      else if (r < 15)
      begin
        op  = opcode_e'(OP_APB_RD + $urandom % 2);
        arg = OPERAND_W'($urandom);
      end
      else
      begin
        op  = OP_NOP;
        arg = '0;
      end
      rom[i].opcode  = op;
      rom[i].operand = arg;
    end
    rom[PM_DEPTH-1].opcode  = OP_JMP;            // Park here at the end
    rom[PM_DEPTH-1].operand = OPERAND_W'(PM_DEPTH - 1);
  endtask

  // ----------------------------------------
  // ISA level reference model
  // ----------------------------------------
  task automatic run_reference_model();
    int     pc;
    int     here;
    int     steps;
    int     rd_n;
    logic   cr;
    logic   m;
    logic   halted;
    logic   mem [0:DM_DEPTH-1];
    instr_t ins;
    pc        = 0;
    steps     = 0;
    rd_n      = 0;
    cr        = 1'b0;
    halted    = 1'b0;
    exp_total = 0;
    while (!halted && steps < 4 * PM_DEPTH)
    begin
      ins  = rom[pc];
      m    = mem[ins.operand[DM_ADDR_W-1:0]];
      here = pc;
      pc   = pc + 1;
      steps++;
      case (ins.opcode)
        OP_LD:     cr = m;
        OP_LDN:    cr = ~m;
        OP_AND:    cr = cr & m;
        OP_ANDN:   cr = cr & ~m;
        OP_OR:     cr = cr | m;
        OP_ORN:    cr = cr | ~m;
        OP_XOR:    cr = cr ^ m;
        OP_XORN:   cr = cr ^ ~m;
        OP_EQU:    cr = (cr == m);
        OP_ST:     mem[ins.operand[DM_ADDR_W-1:0]] = cr;
        OP_STN:    mem[ins.operand[DM_ADDR_W-1:0]] = ~cr;
        OP_S:      if (cr) mem[ins.operand[DM_ADDR_W-1:0]] = 1'b1;
        OP_R:      if (cr) mem[ins.operand[DM_ADDR_W-1:0]] = 1'b0;
        OP_JMP:
        begin
          halted = (int'(ins.operand) == here);
          pc     = int'(ins.operand);
        end
        OP_JMPC:   if (cr) pc = int'(ins.operand);
        OP_JMPCN:  if (!cr) pc = int'(ins.operand);
        OP_APB_RD:
        begin
          mon0.expect_transfer(ins.operand, 1'b0, 1'b0);
          exp_total++;
          cr = rd_bits[rd_n];
          rd_n++;
        end
        OP_APB_WR:
        begin
          mon0.expect_transfer(ins.operand, 1'b1, cr);
          exp_total++;
        end
        default:   cr = cr;
      endcase
    end
  endtask

  task automatic print_error_counts(input int timeouts);
    $display("Errors: %0d mismatches, %0d assertions, %0d other, %0d timeouts (%0d of %0d seen)",
             mismatch_count, assert_errors, other_count, timeouts, seen_count, exp_total);
  endtask

  // ----------------------------------------
  // APB slave with random wait states
  // ----------------------------------------
  always @(posedge cpu_clk)
  begin
    #1;
    if (apb.psel && !apb.penable)                // Setup phase
    begin
      wait_left = wait_cycles[xfer_idx];
      pready    = 1'b0;
      if (!apb.pwrite)
        prdata = rd_bits[rd_idx];
    end
    else if (apb.psel && apb.penable)
    begin
      if (wait_left == 0)
      begin
        pready = 1'b1;
        xfer_idx++;
        if (!apb.pwrite)
          rd_idx++;
      end
      else
      begin
        pready = 1'b0;
        wait_left--;
      end
    end
    else
      pready = 1'b0;
  end

  initial
  begin
    cpu_clk    = 1'b0;
    cpu_resetn = 1'b0;
    cpu_run    = 1'b0;
    pready     = 1'b0;
    prdata     = 1'b0;
    xfer_idx   = 0;
    rd_idx     = 0;
    wait_left  = 0;
    seed       = 62;
    void'($urandom(seed));
    build_program();
    run_reference_model();
    repeat (5) @(posedge cpu_clk);
    #1 cpu_resetn = 1'b1;
    repeat (3) @(posedge cpu_clk);               // Idle check window
    #1 cpu_run = 1'b1;
    wait (seen_count >= exp_total);
    repeat (20) @(posedge cpu_clk);              // Room for stray transfers
    print_error_counts(0);
    if (mismatch_count == 0 && other_count == 0 && assert_errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: APB transfers are missing, only %0d of %0d were seen",
             seen_count, exp_total);
    print_error_counts(1);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule
